// ==== rtl/lz77_prc_config.svh ====
/*
 * LZ77 input processor constants.
 * Widths, output buffer credits and action table size.
 */
`ifndef LZ77_PRC_CONFIG_SVH
`define LZ77_PRC_CONFIG_SVH

`define LOB_CREDITS   32  // Output buffer slots after reset.
`define TLV_DATA_W    64
`define NUM_TLV_TYPES 32  // Entries in the action table.
`define FRAME_NUM_W   11
`define SAMPLE_BYTES  4   // Bytes per engine sample.

`endif

// ==== rtl/tlv_pkg.sv ====
/*
 * TLV stream types.
 * Bus word layout, TLV type codes, per-type action and header word.
 */
`include "lz77_prc_config.svh"

package tlv_pkg;

   // One word of the TLV stream, 84 bits.
   typedef struct packed {
      logic [7:0]             typen;
      logic                   eot;
      logic                   sop;
      logic [1:0]             pad;
      logic [7:0]             tstrb;
      logic [`TLV_DATA_W-1:0] tdata;
   } tlv_bus_t;

   // Codes not listed here take the bypass path.
   typedef enum logic [7:0] {
      CMD      = 8'd1,
      DATA     = 8'd2,
      DATA_UNK = 8'd3,
      FTR      = 8'd4,
      PFD      = 8'd5
   } tlv_type_e;

   typedef enum logic [1:0] {
      MODIFY = 2'd0,
      DELETE = 2'd1  // Codes 2 and 3 also delete.
   } tlv_action_e;

   typedef struct packed {
      logic [`TLV_DATA_W-`FRAME_NUM_W-1:0] rsvd;
      logic [`FRAME_NUM_W-1:0]             frame_num;
   } tlv_word0_t;

endpackage

// ==== rtl/lz77_cfg_pkg.sv ====
/*
 * Compression settings types.
 * Command word fields, footer error codes and the engine sample.
 */
`include "lz77_prc_config.svh"

package lz77_cfg_pkg;

   typedef enum logic [3:0] {
      NONE  = 4'd0,
      ZLIB  = 4'd1,
      GZIP  = 4'd2,
      XP9   = 4'd3,
      XP10  = 4'd4,
      CHU4K = 4'd5,
      CHU8K = 4'd6  // Higher codes are illegal.
   } comp_mode_e;

   typedef enum logic [2:0] {
      WIN_32B = 3'd0,
      WIN_4K  = 3'd1,
      WIN_8K  = 3'd2,
      WIN_16K = 3'd3,
      WIN_32K = 3'd4,
      WIN_64K = 3'd5
   } win_size_e;

   typedef enum logic [1:0] {
      LEN_LZ77_WIN = 2'd0,
      LEN_256B     = 2'd1,
      MIN_MTCH_14  = 2'd2,
      LEN_64B      = 2'd3
   } max_len_e;

   typedef enum logic [1:0] {
      CHAR_1  = 2'd0,
      CHAR_2  = 2'd1,
      CHAR_3  = 2'd2,
      RSV_DLY = 2'd3
   } dly_win_e;

   // Second command word.
   typedef struct packed {
      logic [`TLV_DATA_W-13:0] rsvd;
      logic                    min_match_len;
      dly_win_e                dly_win;
      max_len_e                max_len;
      win_size_e               win_size;
      comp_mode_e              comp_mode;
   } cmd_word2_t;

   typedef enum logic [7:0] {
      NO_ERRORS        = 8'd0,
      INVALID_COMP_ALG = 8'd1,
      INVALID_WIN_SIZE = 8'd2,
      INVALID_MAX_LEN  = 8'd3,
      INVALID_DMW_SIZE = 8'd4
   } err_code_e;

   // Last footer word.
   typedef struct packed {
      logic [`TLV_DATA_W-41:0] rsvd;
      logic [31:0]             errored_frame_number;
      err_code_e               error_code;
   } footer_word_t;

   typedef struct packed {
      logic bad_comp_alg;
      logic bad_win_size;
      logic bad_max_len;
      logic bad_dmw_size;
   } cfg_err_t;

   typedef struct packed {
      logic [`SAMPLE_BYTES*8-1:0] data;
      logic [`SAMPLE_BYTES-1:0]   data_vld;
      logic                       eot;
   } lec_sample_t;

endpackage

// ==== rtl/tlv_route_fsm.sv ====
/*
 * TLV routing state machine.
 * Looks up the action per TLV, pops parser words, pushes to the output
 * buffer under credit, and strobes command capture and engine samples.
 */
`timescale 1ns/100ps
`include "lz77_prc_config.svh"

module tlv_route_fsm (
   input  logic                         clk,
   input  logic                         rst_n,
   input  tlv_pkg::tlv_bus_t            i_prs_tlv,
   input  logic                         i_prs_empty,
   input  logic [2*`NUM_TLV_TYPES-1:0]  i_tlv_action,
   input  logic                         i_lob_credit,
   input  logic                         i_compress_en,
   output logic                         o_prs_rd,
   output logic                         o_lob_valid,
   output logic                         o_lob_is_compressed,
   output logic                         o_cmd_capture_w1,
   output logic                         o_cmd_capture_w2,
   output logic                         o_footer_last,
   output logic [`FRAME_NUM_W-1:0]      o_command_frame_num,
   output logic                         o_sample_strb,
   output logic                         o_sample_sel_low,
   output logic                         o_sample_eot
);
   import tlv_pkg::*;

   localparam int IDX_W    = $clog2(`NUM_TLV_TYPES);
   localparam int CREDIT_W = $clog2(`LOB_CREDITS + 1);

   typedef enum logic [2:0] {
      WORD_ZERO, CMD_TLV, COMP_DATA_1, COMP_DATA_2, FOOTER_TLV, BYPASS_TLV
   } state_e;

   state_e                state, state_nxt;
   tlv_action_e           lookup_action, action_r;
   logic [1:0]            act_field;
   logic [CREDIT_W-1:0]   credit_cnt;
   logic                  have_credit;
   logic                  w1_done;
   logic                  word_pass;
   logic                  is_data;
   tlv_word0_t            word0;

   assign act_field = i_tlv_action[{i_prs_tlv.typen[IDX_W-1:0], 1'b0} +: 2];
   assign lookup_action = (i_prs_tlv.typen < `NUM_TLV_TYPES && act_field == MODIFY) ?
                          MODIFY : DELETE;  // Out of table or codes 2/3 delete.
   assign have_credit = (credit_cnt != '0);
   assign is_data = (i_prs_tlv.typen == DATA) || (i_prs_tlv.typen == DATA_UNK);
   assign word0 = i_prs_tlv.tdata;

   always_comb begin
      state_nxt           = state;
      word_pass           = 1'b0;
      o_prs_rd            = 1'b0;
      o_lob_valid         = 1'b0;
      o_lob_is_compressed = 1'b0;
      o_cmd_capture_w1    = 1'b0;
      o_cmd_capture_w2    = 1'b0;
      o_footer_last       = 1'b0;
      o_sample_strb       = 1'b0;
      o_sample_sel_low    = 1'b0;
      o_sample_eot        = 1'b0;
      case (state)
         WORD_ZERO: begin
            if (!i_prs_empty && (lookup_action != MODIFY || have_credit)) begin
               o_prs_rd            = 1'b1;
               o_lob_valid         = (lookup_action == MODIFY);
               o_lob_is_compressed = o_lob_valid && is_data && i_compress_en;
               if (!i_prs_tlv.eot) begin
                  case (i_prs_tlv.typen)
                     CMD:            state_nxt = CMD_TLV;
                     DATA, DATA_UNK: state_nxt = COMP_DATA_1;
                     FTR:            state_nxt = FOOTER_TLV;
                     default:        state_nxt = BYPASS_TLV;  // Prefix data too.
                  endcase
               end
            end
         end
         COMP_DATA_1: begin
            if (action_r == MODIFY && i_compress_en) begin
               if (!i_prs_empty) begin
                  o_sample_strb = 1'b1;  // Bytes 0..3 first.
                  if (|i_prs_tlv.tstrb[7:4]) begin
                     state_nxt = COMP_DATA_2;
                  end else begin
                     o_prs_rd     = 1'b1;
                     o_sample_eot = 1'b1;
                     state_nxt    = WORD_ZERO;
                  end
               end
            end else begin
               word_pass = 1'b1;
            end
         end
         COMP_DATA_2: begin
            if (!i_prs_empty) begin
               o_sample_strb    = 1'b1;
               o_sample_sel_low = 1'b1;
               o_prs_rd         = 1'b1;
               o_sample_eot     = i_prs_tlv.eot;
               state_nxt        = i_prs_tlv.eot ? WORD_ZERO : COMP_DATA_1;
            end
         end
         default: word_pass = 1'b1;
      endcase

      // Word-by-word path for commands, footers, bypass and plain data.
      if (word_pass && !i_prs_empty && (action_r != MODIFY || have_credit)) begin
         o_prs_rd         = 1'b1;
         o_lob_valid      = (action_r == MODIFY);
         o_cmd_capture_w1 = (state == CMD_TLV) && !w1_done;
         o_cmd_capture_w2 = (state == CMD_TLV) && w1_done;
         if (i_prs_tlv.eot) begin
            state_nxt     = WORD_ZERO;
            o_footer_last = (state == FOOTER_TLV) && o_lob_valid;
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state               <= WORD_ZERO;
         action_r            <= MODIFY;
         w1_done             <= 1'b0;
         credit_cnt          <= CREDIT_W'(`LOB_CREDITS);
         o_command_frame_num <= '0;
      end else begin
         state <= state_nxt;
         if (state == WORD_ZERO)
            action_r <= lookup_action;  // Held for the rest of the TLV.
         if (o_cmd_capture_w1)
            w1_done <= 1'b1;
         else if (o_cmd_capture_w2)
            w1_done <= 1'b0;
         if (o_lob_valid && !i_lob_credit)
            credit_cnt <= credit_cnt - 1'b1;
         else if (!o_lob_valid && i_lob_credit)
            credit_cnt <= credit_cnt + 1'b1;
         if (o_prs_rd && state == WORD_ZERO && i_prs_tlv.typen == CMD)
            o_command_frame_num <= word0.frame_num;
      end
   end

   a_push_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
      (credit_cnt == '0) |-> !o_lob_valid);

endmodule

// ==== rtl/cmd_cfg_check.sv ====
/*
 * Command settings check.
 * Captures the second command word, derives compress enable and
 * flags illegal mode, window, max length and delay combinations.
 */
`timescale 1ns/100ps
`include "lz77_prc_config.svh"

module cmd_cfg_check (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic [`TLV_DATA_W-1:0]  i_tdata,
   input  logic                    i_capture_w1,
   input  logic                    i_capture_w2,
   input  logic                    i_clear,
   output logic                    o_compress_en,
   output lz77_cfg_pkg::cfg_err_t  o_cfg_err
);
   import lz77_cfg_pkg::*;

   cmd_word2_t cmd_w2_in;
   cmd_word2_t cmd_w2;
   logic       w1_seen;
   logic       w2_load;
   logic       check_q;
   logic       win_bad;
   logic       len_bad;
   logic       dmw_bad;
   logic       zlib_like;

   assign cmd_w2_in = i_tdata;
   assign w2_load   = i_capture_w2 && w1_seen;
   assign zlib_like = (cmd_w2.comp_mode == ZLIB) || (cmd_w2.comp_mode == GZIP);

   always_comb begin
      if (cmd_w2.win_size == WIN_32B) begin
         win_bad = 1'b0;
      end else if (cmd_w2.win_size > WIN_64K) begin
         win_bad = 1'b1;
      end else begin
         case (cmd_w2.comp_mode)
            ZLIB, GZIP: win_bad = (cmd_w2.win_size != WIN_32K);
            XP9:        win_bad = (cmd_w2.win_size != WIN_64K);
            CHU4K:      win_bad = (cmd_w2.win_size != WIN_4K);
            CHU8K:      win_bad = (cmd_w2.win_size != WIN_8K);
            XP10:       win_bad = (cmd_w2.win_size == WIN_32K);
            default:    win_bad = 1'b0;
         endcase
      end

      if (cmd_w2.max_len == MIN_MTCH_14 || cmd_w2.max_len == LEN_64B)
         len_bad = 1'b0;
      else if (zlib_like)
         len_bad = (cmd_w2.max_len == LEN_LZ77_WIN);
      else
         len_bad = (cmd_w2.max_len == LEN_256B);

      dmw_bad = (cmd_w2.dly_win == RSV_DLY) || (zlib_like && cmd_w2.dly_win != CHAR_1);
   end

   always_ff @(posedge clk) begin
      if (w2_load)
         cmd_w2 <= cmd_w2_in;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         w1_seen       <= 1'b0;
         check_q       <= 1'b0;
         o_compress_en <= 1'b0;
         o_cfg_err     <= '0;
      end else begin
         if (i_capture_w1)
            w1_seen <= 1'b1;
         else if (i_capture_w2)
            w1_seen <= 1'b0;
         check_q <= w2_load;  // Remaining checks run off the held word.
         if (w2_load)
            o_compress_en <= (cmd_w2_in.comp_mode != NONE) && (cmd_w2_in.comp_mode <= CHU8K);
         if (i_clear) begin
            o_cfg_err <= '0;
         end else begin
            if (w2_load)
               o_cfg_err.bad_comp_alg <= (cmd_w2_in.comp_mode > CHU8K);
            if (check_q) begin
               o_cfg_err.bad_win_size <= win_bad;
               o_cfg_err.bad_max_len  <= len_bad;
               o_cfg_err.bad_dmw_size <= dmw_bad;
            end
         end
      end
   end

   // Word 2 of a command always follows word 1.
   a_w2_after_w1: assert property (@(posedge clk) disable iff (!rst_n)
      i_capture_w2 |-> w1_seen);

endmodule

// ==== rtl/footer_error_update.sv ====
/*
 * Footer error update.
 * Encodes the highest-priority settings error and writes it, with the
 * command frame number, into the last footer word when none is set.
 */
`timescale 1ns/100ps
`include "lz77_prc_config.svh"

module footer_error_update (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic [`TLV_DATA_W-1:0]   i_tdata,
   input  logic                     i_footer_last,
   input  lz77_cfg_pkg::cfg_err_t   i_cfg_err,
   input  logic [`FRAME_NUM_W-1:0]  i_command_frame_num,
   output logic [`TLV_DATA_W-1:0]   o_footer_word,
   output logic                     o_footer_rewrite
);
   import lz77_cfg_pkg::*;

   err_code_e               code_nxt;
   err_code_e               err_code;
   logic [`FRAME_NUM_W-1:0] err_frame;
   footer_word_t            ftr_in;
   footer_word_t            ftr_out;

   always_comb begin
      case (1'b1)
         i_cfg_err.bad_comp_alg: code_nxt = INVALID_COMP_ALG;
         i_cfg_err.bad_win_size: code_nxt = INVALID_WIN_SIZE;
         i_cfg_err.bad_max_len:  code_nxt = INVALID_MAX_LEN;
         i_cfg_err.bad_dmw_size: code_nxt = INVALID_DMW_SIZE;
         default:                code_nxt = NO_ERRORS;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         err_code  <= NO_ERRORS;
         err_frame <= '0;
      end else begin
         err_code  <= code_nxt;
         err_frame <= (code_nxt == NO_ERRORS) ? '0 : i_command_frame_num;
      end
   end

   assign ftr_in = i_tdata;

   // An error already reported upstream is left in place.
   assign o_footer_rewrite = i_footer_last && (err_code != NO_ERRORS) &&
                             (ftr_in.error_code == NO_ERRORS);

   always_comb begin
      ftr_out                      = ftr_in;
      ftr_out.error_code           = err_code;
      ftr_out.errored_frame_number = 32'(err_frame);  // Zero-extended.
   end

   assign o_footer_word = ftr_out;

endmodule

// ==== rtl/lec_sample_out.sv ====
/*
 * Engine sample output.
 * Byte-swaps the data word, picks one 4-byte half and registers it.
 */
`timescale 1ns/100ps
`include "lz77_prc_config.svh"

module lec_sample_out (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic [`TLV_DATA_W-1:0]     i_tdata,
   input  logic [`TLV_DATA_W/8-1:0]   i_tstrb,
   input  logic                       i_strb,
   input  logic                       i_sel_low,
   input  logic                       i_eot,
   output lz77_cfg_pkg::lec_sample_t  o_sample
);
   import lz77_cfg_pkg::*;

   localparam int NB = `TLV_DATA_W / 8;
   localparam int SW = `SAMPLE_BYTES * 8;

   logic [`TLV_DATA_W-1:0] swp_data;
   logic [NB-1:0]          swp_strb;
   lec_sample_t            sample_nxt;

   always_comb begin
      for (int i = 0; i < NB; i++) begin
         swp_data[`TLV_DATA_W-1-8*i -: 8] = i_tdata[8*i +: 8];  // Byte 0 to the top.
         swp_strb[NB-1-i] = i_tstrb[i];
      end
      sample_nxt = '0;
      if (i_strb) begin
         sample_nxt.data     = i_sel_low ? swp_data[SW-1:0] : swp_data[2*SW-1 -: SW];
         sample_nxt.data_vld = i_sel_low ? swp_strb[`SAMPLE_BYTES-1:0] :
                                           swp_strb[NB-1 -: `SAMPLE_BYTES];
         sample_nxt.eot      = i_eot;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         o_sample <= '0;
      else
         o_sample <= sample_nxt;
   end

   a_eot_has_bytes: assert property (@(posedge clk) disable iff (!rst_n)
      o_sample.eot |-> |o_sample.data_vld);

endmodule

// ==== rtl/lz77_prc_top.sv ====
/*
 * LZ77 compressor input processor.
 * Routes TLVs to the output buffer, checks command settings, feeds
 * samples to the engine and patches footer errors.
 */
`timescale 1ns/100ps
`include "lz77_prc_config.svh"

module lz77_prc_top (
   input  logic                         clk,
   input  logic                         rst_n,
   input  tlv_pkg::tlv_bus_t            i_prs_tlv,
   input  logic                         i_prs_empty,
   output logic                         o_prs_rd,
   input  logic [2*`NUM_TLV_TYPES-1:0]  i_tlv_action,
   output logic                         o_lob_valid,
   output tlv_pkg::tlv_bus_t            o_lob_tlv,
   output logic                         o_lob_is_compressed,
   input  logic                         i_lob_credit,
   output lz77_cfg_pkg::lec_sample_t    o_lec_sample
);
   import tlv_pkg::*;
   import lz77_cfg_pkg::*;

   logic                    compress_en;
   logic                    cmd_capture_w1;
   logic                    cmd_capture_w2;
   logic                    footer_last;
   logic                    footer_rewrite;
   logic                    sample_strb;
   logic                    sample_sel_low;
   logic                    sample_eot;
   logic [`FRAME_NUM_W-1:0] command_frame_num;
   logic [`TLV_DATA_W-1:0]  footer_word;
   cfg_err_t                cfg_err;
   tlv_bus_t                footer_tlv;

   tlv_route_fsm u_fsm (
      .clk                 (clk),
      .rst_n               (rst_n),
      .i_prs_tlv           (i_prs_tlv),
      .i_prs_empty         (i_prs_empty),
      .i_tlv_action        (i_tlv_action),
      .i_lob_credit        (i_lob_credit),
      .i_compress_en       (compress_en),
      .o_prs_rd            (o_prs_rd),
      .o_lob_valid         (o_lob_valid),
      .o_lob_is_compressed (o_lob_is_compressed),
      .o_cmd_capture_w1    (cmd_capture_w1),
      .o_cmd_capture_w2    (cmd_capture_w2),
      .o_footer_last       (footer_last),
      .o_command_frame_num (command_frame_num),
      .o_sample_strb       (sample_strb),
      .o_sample_sel_low    (sample_sel_low),
      .o_sample_eot        (sample_eot)
   );

   cmd_cfg_check u_cfg (
      .clk           (clk),
      .rst_n         (rst_n),
      .i_tdata       (i_prs_tlv.tdata),
      .i_capture_w1  (cmd_capture_w1),
      .i_capture_w2  (cmd_capture_w2),
      .i_clear       (footer_last),
      .o_compress_en (compress_en),
      .o_cfg_err     (cfg_err)
   );

   footer_error_update u_ftr (
      .clk                 (clk),
      .rst_n               (rst_n),
      .i_tdata             (i_prs_tlv.tdata),
      .i_footer_last       (footer_last),
      .i_cfg_err           (cfg_err),
      .i_command_frame_num (command_frame_num),
      .o_footer_word       (footer_word),
      .o_footer_rewrite    (footer_rewrite)
   );

   lec_sample_out u_lec (
      .clk       (clk),
      .rst_n     (rst_n),
      .i_tdata   (i_prs_tlv.tdata),
      .i_tstrb   (i_prs_tlv.tstrb),
      .i_strb    (sample_strb),
      .i_sel_low (sample_sel_low),
      .i_eot     (sample_eot),
      .o_sample  (o_lec_sample)
   );

   // Only the data field of the footer word is replaced.
   always_comb begin
      footer_tlv       = i_prs_tlv;
      footer_tlv.tdata = footer_word;
   end

   assign o_lob_tlv = footer_rewrite ? footer_tlv : i_prs_tlv;

endmodule

// ==== test/tb_lz77_prc_table.svh ====
/*
 * Frame table for the LZ77 input processor testbench.
 * Each row is one TLV, plus the rule functions for expected results.
 */
`ifndef TB_LZ77_PRC_TABLE_SVH
`define TB_LZ77_PRC_TABLE_SVH

// Columns: type, action, mode, window, max len, delay, bytes, footer error, hold credits.
typedef struct packed {
   logic [7:0]  typen;
   logic [1:0]  act;
   logic [3:0]  mode;
   logic [2:0]  win;
   logic [1:0]  mlen;
   logic [1:0]  dly;
   logic [15:0] nbytes;
   logic [7:0]  ftr_err;
   logic        hold;
} frame_t;

localparam int NUM_FRAMES = 20;

frame_t frame_tab [NUM_FRAMES] = '{
   '{8'd9,  2'd0, 4'd0, 3'd0, 2'd0, 2'd0, 16'd20,  8'h00, 1'b0},  // Bypass, pushed.
   '{8'd12, 2'd1, 4'd0, 3'd0, 2'd0, 2'd0, 16'd24,  8'h00, 1'b0},  // Bypass, deleted.
   '{8'd1,  2'd0, 4'd1, 3'd4, 2'd1, 2'd0, 16'd0,   8'h00, 1'b0},  // Legal ZLIB.
   '{8'd2,  2'd0, 4'd0, 3'd0, 2'd0, 2'd0, 16'd21,  8'h00, 1'b0},
   '{8'd3,  2'd0, 4'd0, 3'd0, 2'd0, 2'd0, 16'd19,  8'h00, 1'b0},
   '{8'd2,  2'd1, 4'd0, 3'd0, 2'd0, 2'd0, 16'd16,  8'h00, 1'b0},
   '{8'd4,  2'd0, 4'd0, 3'd0, 2'd0, 2'd0, 16'd0,   8'h00, 1'b0},
   '{8'd1,  2'd0, 4'd0, 3'd0, 2'd0, 2'd0, 16'd0,   8'h00, 1'b0},  // Mode NONE.
   '{8'd2,  2'd0, 4'd0, 3'd0, 2'd0, 2'd0, 16'd13,  8'h00, 1'b0},
   '{8'd1,  2'd0, 4'd7, 3'd3, 2'd0, 2'd0, 16'd0,   8'h00, 1'b0},
   '{8'd4,  2'd0, 4'd0, 3'd0, 2'd0, 2'd0, 16'd0,   8'h00, 1'b0},
   '{8'd1,  2'd0, 4'd4, 3'd4, 2'd1, 2'd3, 16'd0,   8'h00, 1'b0},
   '{8'd4,  2'd0, 4'd0, 3'd0, 2'd0, 2'd0, 16'd0,   8'h00, 1'b0},
   '{8'd1,  2'd0, 4'd2, 3'd4, 2'd0, 2'd1, 16'd0,   8'h00, 1'b0},
   '{8'd4,  2'd0, 4'd0, 3'd0, 2'd0, 2'd0, 16'd0,   8'h00, 1'b0},
   '{8'd1,  2'd0, 4'd5, 3'd1, 2'd2, 2'd3, 16'd0,   8'h00, 1'b0},
   '{8'd4,  2'd0, 4'd0, 3'd0, 2'd0, 2'd0, 16'd0,   8'h05, 1'b0},  // Already errored.
   '{8'd5,  2'd0, 4'd0, 3'd0, 2'd0, 2'd0, 16'd9,   8'h00, 1'b0},
   '{8'd9,  2'd0, 4'd0, 3'd0, 2'd0, 2'd0, 16'd320, 8'h00, 1'b1},
   '{8'd40, 2'd0, 4'd0, 3'd0, 2'd0, 2'd0, 16'd8,   8'h00, 1'b0}   // Out of table.
};

function automatic int words_of(input frame_t f);
   if (f.typen == 8'd1 || f.typen == 8'd4)
      return 3;
   return 1 + (int'(f.nbytes) + 7) / 8;
endfunction

function automatic logic compress_ok(input logic [3:0] mode);
   return (mode != 4'd0) && (mode <= 4'd6);
endfunction

function automatic logic [7:0] err_code_of(input frame_t f);
   logic zl;
   logic win_err;
   zl = (f.mode == 4'd1) || (f.mode == 4'd2);
   case (f.mode)
      4'd1, 4'd2: win_err = (f.win != 3'd4);
      4'd3:       win_err = (f.win != 3'd5);
      4'd4:       win_err = (f.win == 3'd4);
      4'd5:       win_err = (f.win != 3'd1);
      4'd6:       win_err = (f.win != 3'd2);
      default:    win_err = 1'b0;
   endcase
   if (f.win == 3'd0)
      win_err = 1'b0;
   else if (f.win > 3'd5)
      win_err = 1'b1;
   if (f.mode > 4'd6)
      return 8'd1;
   if (win_err)
      return 8'd2;
   if (f.mlen < 2'd2 && (zl ? (f.mlen == 2'd0) : (f.mlen == 2'd1)))
      return 8'd3;
   if (f.dly == 2'd3 || (zl && f.dly != 2'd0))
      return 8'd4;
   return 8'd0;
endfunction

`endif

// ==== test/tb_lz77_prc.sv ====
/*
 * Testbench for the LZ77 input processor.
 * Feeds table frames through a parser model, returns credits and
 * checks output buffer pushes and engine samples in order.
 */
`timescale 1ns/100ps
`include "lz77_prc_config.svh"

module tb_lz77_prc;
   import tlv_pkg::*;
   import lz77_cfg_pkg::*;

   `include "tb_lz77_prc_table.svh"

   typedef struct packed {
      tlv_bus_t tlv;
      logic     comp;
   } push_t;

   logic        clk;
   logic        rst_n;
   tlv_bus_t    i_prs_tlv;
   logic        i_prs_empty;
   logic        o_prs_rd;
   logic [63:0] i_tlv_action;
   logic        o_lob_valid;
   tlv_bus_t    o_lob_tlv;
   logic        o_lob_is_compressed;
   logic        i_lob_credit;
   lec_sample_t o_lec_sample;

   tlv_bus_t    prs_q[$];
   push_t       exp_push[$];
   lec_sample_t exp_samp[$];
   logic [31:0] lcg_state = 32'hd6e0_2135;
   logic [10:0] frame_num = 11'h10;
   logic        model_comp_en = 1'b0;
   logic [7:0]  model_err = 8'h00;
   logic [10:0] model_err_frame = '0;
   bit          hold_credit = 0;
   int          credit_pending = 0;
   int          push_count = 0;
   int          cycle_cnt = 0;
   int          cycle_limit = 0;

   lz77_prc_top UUT (.*);

   always #5 clk = ~clk;

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   task automatic check_value(input string name, input logic [127:0] got,
                              input logic [127:0] exp);
      if (got !== exp) begin
         $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
         $display("Simulation failed");
         $fatal(1, "value check");
      end
   endtask

   task automatic stop_run(input string why);
      $display("Error: %s", why);
      $display("Simulation failed");
      $fatal(1, "run stopped");
   endtask

   // Expected sample from one half of a payload word.
   function automatic lec_sample_t half_sample(input tlv_bus_t w, input bit low,
                                               input logic eot);
      lec_sample_t s;
      int b;
      b = low ? 4 : 0;
      s.data     = {w.tdata[8*b +: 8], w.tdata[8*(b+1) +: 8],
                    w.tdata[8*(b+2) +: 8], w.tdata[8*(b+3) +: 8]};
      s.data_vld = {w.tstrb[b], w.tstrb[b+1], w.tstrb[b+2], w.tstrb[b+3]};
      s.eot      = eot;
      return s;
   endfunction

   task automatic build_frame(input frame_t f);
      tlv_bus_t words[$];
      tlv_bus_t w;
      int       nw;
      int       k;
      bit       modify;
      modify = (f.typen < 8'd32) && (f.act == 2'd0);
      w = '0;
      w.typen = f.typen;
      w.sop   = 1'b1;
      w.tstrb = 8'hff;
      w.tdata = {lcg_next(), lcg_next()};
      w.tdata[10:0] = frame_num;
      words.push_back(w);
      nw = words_of(f) - 1;
      for (int j = 0; j < nw; j++) begin
         w = '0;
         w.typen = f.typen;
         w.eot   = (j == nw - 1);
         w.tdata = {lcg_next(), lcg_next()};
         k = (f.typen == 8'd1 || f.typen == 8'd4 || !w.eot) ? 8 : int'(f.nbytes) - 8 * j;
         w.tstrb = 8'((9'h1 << k) - 1);
         if (f.typen == 8'd1 && w.eot)
            w.tdata = {52'h0, 1'b0, f.dly, f.mlen, f.win, f.mode};
         if (f.typen == 8'd4 && w.eot)
            w.tdata[7:0] = f.ftr_err;
         words.push_back(w);
      end
      foreach (words[j])
         prs_q.push_back(words[j]);

      if (modify && (f.typen == 8'd2 || f.typen == 8'd3) && model_comp_en) begin
         exp_push.push_back('{tlv: words[0], comp: 1'b1});
         for (int j = 1; j < words.size(); j++) begin
            w = words[j];
            exp_samp.push_back(half_sample(w, 0, w.eot && w.tstrb[7:4] == 4'h0));
            if (w.tstrb[7:4] != 4'h0)
               exp_samp.push_back(half_sample(w, 1, w.eot));
         end
      end else if (modify) begin
         foreach (words[j]) begin
            w = words[j];
            if (f.typen == 8'd4 && w.eot && model_err != 8'h00 && f.ftr_err == 8'h00) begin
               w.tdata[7:0]  = model_err;
               w.tdata[39:8] = 32'(model_err_frame);
            end
            exp_push.push_back('{tlv: w, comp: 1'b0});
         end
         if (f.typen == 8'd4)
            model_err = 8'h00;  // Flags clear after the footer.
      end
      if (modify && f.typen == 8'd1) begin
         model_comp_en   = compress_ok(f.mode);
         model_err       = err_code_of(f);
         model_err_frame = frame_num;
      end
      frame_num = frame_num + 1'b1;
   endtask

   // Parser model and credit return, in one process for a fixed LCG order.
   always @(posedge clk) begin
      logic [31:0] r;
      if (o_prs_rd) begin
         if (i_prs_empty)
            stop_run("DUT read from the parser while it was empty");
         else
            void'(prs_q.pop_front());
      end
      r = lcg_next();
      if (prs_q.size() != 0 && r[18:16] != 3'd0) begin
         i_prs_tlv   <= prs_q[0];
         i_prs_empty <= 1'b0;
      end else begin
         i_prs_empty <= 1'b1;
      end
      if (o_lob_valid)
         credit_pending++;
      if (!hold_credit && credit_pending > 0 && r[25:24] == 2'd0) begin
         i_lob_credit <= 1'b1;
         credit_pending--;
      end else begin
         i_lob_credit <= 1'b0;
      end
   end

   always @(posedge clk) begin
      push_t       ep;
      lec_sample_t es;
      if (rst_n && o_lob_valid) begin
         push_count++;
         if (exp_push.size() == 0) begin
            stop_run("push to the output buffer that was not expected");
         end else begin
            ep = exp_push.pop_front();
            check_value("o_lob_tlv", 128'(o_lob_tlv), 128'(ep.tlv));
            check_value("o_lob_is_compressed", 128'(o_lob_is_compressed), 128'(ep.comp));
         end
      end
      if (rst_n && o_lec_sample != '0) begin
         if (exp_samp.size() == 0) begin
            stop_run("engine sample that was not expected");
         end else begin
            es = exp_samp.pop_front();
            check_value("o_lec_sample", 128'(o_lec_sample), 128'(es));
         end
      end
   end

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_limit != 0 && cycle_cnt > cycle_limit)
         stop_run("timeout, the DUT stopped making progress");
   end

   initial begin
      int total;
      int base;
      clk          = 1'b0;
      rst_n        = 1'b0;
      i_prs_tlv    = '0;
      i_prs_empty  = 1'b1;
      i_tlv_action = '0;
      i_lob_credit = 1'b0;
      total = 0;
      foreach (frame_tab[i])
         total += words_of(frame_tab[i]);
      cycle_limit = total * 8 + 100;
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;

      foreach (frame_tab[i]) begin
         while (prs_q.size() != 0)
            @(posedge clk);
         repeat (3) @(posedge clk);
         if (frame_tab[i].typen < 8'd32)
            i_tlv_action[2 * int'(frame_tab[i].typen) +: 2] <= frame_tab[i].act;
         if (frame_tab[i].hold) begin
            while (credit_pending != 0)
               @(posedge clk);
            repeat (3) @(posedge clk);  // Let the last returns land.
         end
         @(negedge clk);
         hold_credit = frame_tab[i].hold;
         base = push_count;
         build_frame(frame_tab[i]);
         if (frame_tab[i].hold) begin
            while (push_count - base < `LOB_CREDITS)
               @(posedge clk);
            repeat (20) @(posedge clk);
            @(negedge clk);
            check_value("push_count", 128'(push_count - base), 128'(`LOB_CREDITS));
            hold_credit = 0;
         end
      end

      while (prs_q.size() != 0)
         @(posedge clk);
      repeat (3) @(posedge clk);
      if (exp_push.size() == 0 && exp_samp.size() == 0) begin
         $display("Simulation completed successfully");
         $finish;
      end else begin
         $display("Simulation failed");
         $fatal(1, "expected outputs left over");
      end
   end

endmodule

// ==== sim.f ====
+incdir+rtl
+incdir+test
rtl/tlv_pkg.sv
rtl/lz77_cfg_pkg.sv
rtl/tlv_route_fsm.sv
rtl/cmd_cfg_check.sv
rtl/footer_error_update.sv
rtl/lec_sample_out.sv
rtl/lz77_prc_top.sv
test/tb_lz77_prc.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_lz77_prc -f sim.f

out=$(./obj_dir/Vtb_lz77_prc 2>&1) || true
echo "$out"
echo "$out" | grep -q "Simulation completed successfully"
